/* hdl/sram_fifo_consts.svh */
`ifndef SRAM_FIFO_CONSTS_SVH
`define SRAM_FIFO_CONSTS_SVH

// bits per queue word.
`define SRAM_FIFO_WIDTH 16

// words held by the array, not counting the output buffer.
`define SRAM_FIFO_DEPTH 16

// array count at which almost-full rises.
`define SRAM_FIFO_THRESHOLD 12

// address bits for DEPTH words.
`define SRAM_FIFO_PTR_WIDTH 4

`endif

/* hdl/sram_fifo_pkg.sv */
`include "sram_fifo_consts.svh"

package sram_fifo_pkg;

  // one payload word.
  typedef logic [`SRAM_FIFO_WIDTH-1:0] fifo_word_t;

  // array address.
  typedef logic [`SRAM_FIFO_PTR_WIDTH-1:0] fifo_ptr_t;

  // array occupancy, 0 to DEPTH inclusive.
  typedef logic [`SRAM_FIFO_PTR_WIDTH:0] fifo_count_t;

  // prefetch FSM states.
  typedef enum logic {
    IDLE,     // no read in flight.
    READING   // array read data returns next edge.
  } read_state_e;

endpackage

/* hdl/fifo_pointer_counter.sv */
`include "sram_fifo_consts.svh"

module fifo_pointer_counter (
  input   var                           i_clk,
  input   var                           i_rst_n,
  input   var                           i_clear,
  input   var                           i_write_en,
  input   var                           i_read_en,
  output  var sram_fifo_pkg::fifo_ptr_t   o_write_ptr,
  output  var sram_fifo_pkg::fifo_ptr_t   o_read_ptr,
  output  var sram_fifo_pkg::fifo_count_t o_count,
  output  var                           o_empty,
  output  var                           o_full,
  output  var                           o_almost_full
);
  import sram_fifo_pkg::*;

  localparam fifo_ptr_t   LAST_ADDR = fifo_ptr_t'(`SRAM_FIFO_DEPTH - 1);
  localparam fifo_count_t DEPTH     = fifo_count_t'(`SRAM_FIFO_DEPTH);
  localparam fifo_count_t THRESHOLD = fifo_count_t'(`SRAM_FIFO_THRESHOLD);

  fifo_count_t count_next;

  // count moves by one, a write and a read together cancel.
  always_comb begin
    count_next = o_count;
    case ({i_write_en, i_read_en})
      2'b10:   count_next = o_count + 1'b1;
      2'b01:   count_next = o_count - 1'b1;
      default: count_next = o_count;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      o_write_ptr <= '0;
      o_read_ptr  <= '0;
      o_count     <= '0;
    end else begin
      if (i_write_en) begin
        o_write_ptr <= (o_write_ptr == LAST_ADDR) ? '0 : o_write_ptr + 1'b1; // wrap at depth.
      end
      if (i_read_en) begin
        o_read_ptr <= (o_read_ptr == LAST_ADDR) ? '0 : o_read_ptr + 1'b1;
      end
      o_count <= count_next;
    end
  end

  // flags are taken from the next count so they line up with o_count.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      o_empty       <= 1'b1;
      o_full        <= 1'b0;
      o_almost_full <= 1'b0;
    end else begin
      o_empty       <= (count_next == '0);
      o_full        <= (count_next == DEPTH);
      o_almost_full <= (count_next >= THRESHOLD);
    end
  end

endmodule

/* hdl/sram_array.sv */
`include "sram_fifo_consts.svh"

module sram_array (
  input   var                         i_clk,
  input   var                         i_rst_n,
  input   var                         i_write_en,
  input   var sram_fifo_pkg::fifo_ptr_t  i_write_ptr,
  input   var sram_fifo_pkg::fifo_word_t i_write_data,
  input   var                         i_read_en,
  input   var sram_fifo_pkg::fifo_ptr_t  i_read_ptr,
  output  var sram_fifo_pkg::fifo_word_t o_read_data,
  output  var                         o_read_valid
);
  import sram_fifo_pkg::*;

  fifo_word_t mem [`SRAM_FIFO_DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_write_en) begin
      mem[i_write_ptr] <= i_write_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_read_en) begin
      o_read_data <= mem[i_read_ptr]; // one cycle read latency.
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_read_valid <= 1'b0;
    end else begin
      o_read_valid <= i_read_en;
    end
  end

endmodule

/* hdl/read_prefetch_fsm.sv */
`include "sram_fifo_consts.svh"

module read_prefetch_fsm (
  input   var             i_clk,
  input   var             i_rst_n,
  input   var             i_clear,
  input   var             i_array_empty,
  input   var [1:0]       i_buffer_level,
  input   var             i_pop_accept,
  output  var             o_read_en,
  output  var             o_read_busy
);
  import sram_fifo_pkg::*;

  read_state_e state;
  read_state_e state_next;
  logic [1:0]  pending_level;
  logic        room;

  // buffer words after this edge, counting the read about to land.
  always_comb begin
    pending_level = i_buffer_level + {1'b0, o_read_busy} - {1'b0, i_pop_accept};
    room          = (pending_level < 2'd2);
  end

  // a clear on this edge must not leave a stale read behind it.
  always_comb begin
    o_read_en = !i_clear && !i_array_empty && room;
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (o_read_en) begin
          state_next = READING;
        end
      end
      READING: begin
        if (!o_read_en) begin
          state_next = IDLE; // last read completes.
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    o_read_busy = (state == READING);
  end

endmodule

/* hdl/read_output_buffer.sv */
`include "sram_fifo_consts.svh"

module read_output_buffer (
  input   var                         i_clk,
  input   var                         i_rst_n,
  input   var                         i_clear,
  input   var                         i_fill,
  input   var sram_fifo_pkg::fifo_word_t i_fill_data,
  input   var                         i_pop,
  output  var sram_fifo_pkg::fifo_word_t o_data,
  output  var [1:0]                   o_level,
  output  var                         o_empty,
  output  var                         o_full,
  output  var                         o_pop_accept
);
  import sram_fifo_pkg::*;

  fifo_word_t head;
  fifo_word_t tail;

  always_comb begin
    o_empty      = (o_level == 2'd0);
    o_full       = (o_level == 2'd2);
    o_pop_accept = i_pop && !o_empty;
    o_data       = head; // head word falls through.
  end

  always_ff @(posedge i_clk) begin
    case ({i_fill, o_pop_accept})
      2'b10: begin
        if (o_empty) begin
          head <= i_fill_data;
        end else begin
          tail <= i_fill_data;
        end
      end
      2'b01: head <= tail;
      2'b11: begin
        if (o_full) begin
          head <= tail;
          tail <= i_fill_data;
        end else begin
          head <= i_fill_data; // single word swapped out.
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      o_level <= 2'd0;
    end else if (i_fill && !o_pop_accept) begin
      o_level <= o_level + 2'd1;
    end else if (!i_fill && o_pop_accept) begin
      o_level <= o_level - 2'd1;
    end
  end

endmodule

/* hdl/sram_fifo.sv */
`include "sram_fifo_consts.svh"

module sram_fifo (
  input   var                         i_clk,
  input   var                         i_rst_n,
  input   var                         i_clear,
  input   var                         i_push,
  input   var sram_fifo_pkg::fifo_word_t i_data,
  input   var                         i_pop,
  output  var sram_fifo_pkg::fifo_word_t o_data,
  output  var                         o_empty,
  output  var                         o_completely_empty,
  output  var                         o_almost_full,
  output  var                         o_full,
  output  var                         o_completely_full
);
  import sram_fifo_pkg::*;

  logic        write_en;
  logic        read_en;
  logic        rd_valid;
  logic        read_busy;
  fifo_ptr_t   write_ptr;
  fifo_ptr_t   read_ptr;
  fifo_word_t  rd_data;
  logic        array_empty;
  logic        array_full;
  logic        array_almost_full;
  logic [1:0]  buffer_level;
  logic        buffer_empty;
  logic        buffer_full;
  logic        pop_accept;

  always_comb begin
    write_en = i_push && !array_full; // refused while full.
  end

  fifo_pointer_counter u_counter (
    .i_clk          (i_clk              ),
    .i_rst_n        (i_rst_n            ),
    .i_clear        (i_clear            ),
    .i_write_en     (write_en           ),
    .i_read_en      (read_en            ),
    .o_write_ptr    (write_ptr          ),
    .o_read_ptr     (read_ptr           ),
    .o_count        (                   ),
    .o_empty        (array_empty        ),
    .o_full         (array_full         ),
    .o_almost_full  (array_almost_full  )
  );

  sram_array u_array (
    .i_clk          (i_clk      ),
    .i_rst_n        (i_rst_n    ),
    .i_write_en     (write_en   ),
    .i_write_ptr    (write_ptr  ),
    .i_write_data   (i_data     ),
    .i_read_en      (read_en    ),
    .i_read_ptr     (read_ptr   ),
    .o_read_data    (rd_data    ),
    .o_read_valid   (rd_valid   )
  );

  read_prefetch_fsm u_prefetch (
    .i_clk          (i_clk        ),
    .i_rst_n        (i_rst_n      ),
    .i_clear        (i_clear      ),
    .i_array_empty  (array_empty  ),
    .i_buffer_level (buffer_level ),
    .i_pop_accept   (pop_accept   ),
    .o_read_en      (read_en      ),
    .o_read_busy    (read_busy    )
  );

  read_output_buffer u_buffer (
    .i_clk          (i_clk        ),
    .i_rst_n        (i_rst_n      ),
    .i_clear        (i_clear      ),
    .i_fill         (rd_valid     ),
    .i_fill_data    (rd_data      ),
    .i_pop          (i_pop        ),
    .o_data         (o_data       ),
    .o_level        (buffer_level ),
    .o_empty        (buffer_empty ),
    .o_full         (buffer_full  ),
    .o_pop_accept   (pop_accept   )
  );

  always_comb begin
    o_empty            = buffer_empty;
    o_completely_empty = buffer_empty && array_empty && !read_busy;
    o_almost_full      = array_almost_full;
    o_full             = array_full;
    o_completely_full  = array_full && buffer_full; // DEPTH plus two words.
  end

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;   // 40 ns clock.
  localparam int RESET_CYCLES = 16;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1; // released away from the sampling edge.
  end

endmodule

/* verification/tb_sram_fifo.sv */
`include "sram_fifo_consts.svh"

module tb_sram_fifo;
  timeunit 1ns;
  timeprecision 100ps;
  import sram_fifo_pkg::*;

  localparam int TOTAL_WORDS    = `SRAM_FIFO_DEPTH + 2;   // array plus output buffer.
  localparam int TIMEOUT_CYCLES = 3000;  // tests need about 1200 at most.
  localparam int SETTLE_LIMIT   = 8;
  localparam int DRAIN_LIMIT    = 64;

  logic       clk;
  logic       rst_n;
  logic       clear;
  logic       push;
  fifo_word_t wr_data;
  logic       pop;
  fifo_word_t rd_data;
  logic       empty;
  logic       completely_empty;
  logic       almost_full;
  logic       full;
  logic       completely_full;

  fifo_word_t model[$];   // reference queue.
  string      test_name;
  int         mismatch_count = 0;
  int         other_count = 0;
  int         cycle_count = 0;

  tb_clock_gen u_clock_gen (
    .o_clk   (clk  ),
    .o_rst_n (rst_n)
  );

  sram_fifo u_sram_fifo (
    .i_clk              (clk             ),
    .i_rst_n            (rst_n           ),
    .i_clear            (clear           ),
    .i_push             (push            ),
    .i_data             (wr_data         ),
    .i_pop              (pop             ),
    .o_data             (rd_data         ),
    .o_empty            (empty           ),
    .o_completely_empty (completely_empty),
    .o_almost_full      (almost_full     ),
    .o_full             (full            ),
    .o_completely_full  (completely_full )
  );

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      mismatch_count++;
      $display("Mismatch %s %s: expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_condition(input logic ok, input string text);
    assert (ok) else begin
      other_count++;
      $display("%s: %s", test_name, text);
    end
  endtask

  // strobes act on the rising edge between two falling edges.
  task automatic run_cycle(input logic do_push, input fifo_word_t word, input logic do_pop);
    check_condition(!completely_empty || model.size() == 0,
                    "completely empty flag is high while words are queued");
    check_condition(!completely_full || model.size() == TOTAL_WORDS,
                    "completely full flag is high below capacity");
    if (do_pop && !empty) begin
      if (model.size() == 0) begin
        check_condition(1'b0, "a pop was accepted with nothing queued");
      end else begin
        compare_value("pop data", model[0], rd_data);
        void'(model.pop_front());
      end
    end
    if (do_push && !full) begin
      model.push_back(word);
    end
    push    = do_push;
    wr_data = word;
    pop     = do_pop;
    @(negedge clk);
  endtask

  task automatic clear_cycle(input fifo_word_t word);
    model.delete();
    clear   = 1'b1;
    push    = 1'b1; // dropped since clear has priority.
    wr_data = word;
    pop     = 1'b0;
    @(negedge clk);
    clear = 1'b0;
    push  = 1'b0;
  endtask

  task automatic drain_queue();
    int waited;
    waited = 0;
    while (!completely_empty && waited < DRAIN_LIMIT) begin
      run_cycle(1'b0, '0, 1'b1);
      waited++;
    end
    check_condition(completely_empty, "queue did not drain");
    compare_value("words left in model", 0, model.size());
  endtask

  // with n words pushed and no pops the buffer holds up to two and the array the rest.
  task automatic settle_flags(input int n);
    int         array_words;
    int         waited;
    logic [3:0] expected;
    array_words = (n > 2) ? n - 2 : 0;
    expected = {n == 0, array_words >= `SRAM_FIFO_THRESHOLD,
                array_words == `SRAM_FIFO_DEPTH, n == TOTAL_WORDS};
    waited = 0;
    while ({empty, almost_full, full, completely_full} !== expected && waited < SETTLE_LIMIT) begin
      run_cycle(1'b0, '0, 1'b0);
      waited++;
    end
    check_condition({empty, almost_full, full, completely_full} === expected,
                    $sformatf("flags did not settle within %0d cycles after %0d pushes (%b, not %b)",
                              SETTLE_LIMIT, n, {empty, almost_full, full, completely_full},
                              expected));
  endtask

  task automatic test_reset_state();
    test_name = "reset_state";
    compare_value("empty/completely_empty/almost_full/full/completely_full", 5'b11000,
                  {empty, completely_empty, almost_full, full, completely_full});
  endtask

  task automatic test_ordering();
    test_name = "ordering";
    for (int i = 0; i < 10; i++) begin
      run_cycle(1'b1, fifo_word_t'($urandom), 1'b0);
    end
    drain_queue();
  endtask

  task automatic test_fill_flags();
    test_name = "fill_flags";
    for (int n = 1; n <= TOTAL_WORDS; n++) begin
      run_cycle(1'b1, fifo_word_t'($urandom), 1'b0);
      settle_flags(n);
    end
    compare_value("accepted words", TOTAL_WORDS, model.size());
  endtask

  task automatic test_refusals();
    test_name = "refusals";
    compare_value("full before refused push", 1, full);
    run_cycle(1'b1, fifo_word_t'($urandom), 1'b0);
    run_cycle(1'b0, '0, 1'b0);
    compare_value("completely_full", 1, completely_full);
    drain_queue();
    run_cycle(1'b0, '0, 1'b1); // pop on an empty queue.
    run_cycle(1'b0, '0, 1'b0);
    compare_value("completely_empty after empty pop", 1, completely_empty);
  endtask

  task automatic test_clear();
    test_name = "clear";
    for (int i = 0; i < 6; i++) begin
      run_cycle(1'b1, fifo_word_t'($urandom), 1'b0);
    end
    run_cycle(1'b0, '0, 1'b0);
    clear_cycle(fifo_word_t'($urandom));
    compare_value("completely_empty after clear", 1, completely_empty);
    compare_value("full after clear", 0, full);
    for (int i = 0; i < 4; i++) begin
      run_cycle(1'b1, fifo_word_t'($urandom), 1'b0);
    end
    drain_queue();
  endtask

  task automatic test_streaming();
    logic do_push;
    logic do_pop;
    test_name = "streaming";
    for (int i = 0; i < 300; i++) begin
      // the push-heavy half reaches full and the pop-heavy half runs it back down.
      if (i < 150) begin
        do_push = ($urandom % 4) != 0;
        do_pop  = ($urandom % 2) != 0;
      end else begin
        do_push = ($urandom % 4) == 0;
        do_pop  = ($urandom % 4) != 0;
      end
      run_cycle(do_push, fifo_word_t'($urandom), do_pop);
    end
    drain_queue();
  endtask

  always @(posedge clk) begin
    read_state_e prefetch_state;
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      prefetch_state = u_sram_fifo.u_prefetch.state;
      other_count++;
      $display("timeout after %0d cycles in %s, prefetch FSM in %s", cycle_count, test_name,
               prefetch_state.name());
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    clear   = 1'b0;
    push    = 1'b0;
    wr_data = '0;
    pop     = 1'b0;
    test_name = "startup";
    void'($urandom(45));
    wait (rst_n === 1'b1);
    @(negedge clk);
    test_reset_state();
    test_ordering();
    test_fill_flags();
    test_refusals();
    test_clear();
    test_streaming();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+hdl
hdl/sram_fifo_pkg.sv
hdl/fifo_pointer_counter.sv
hdl/sram_array.sv
hdl/read_prefetch_fsm.sv
hdl/read_output_buffer.sv
hdl/sram_fifo.sv
verification/tb_clock_gen.sv
verification/tb_sram_fifo.sv
